/* design/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Line index width.
// 12 bits give 4096 lines, taken from address bits 13..2.
`define DCACHE_INDEX_BITS 12

// Lowest address that bypasses the cache.
// Everything at or above it goes straight to the bus.
`define DCACHE_UNCACHED_BASE 32'h4000_0000

`endif

/* design/dcache_pkg.sv */
`default_nettype none

// Line word layout, 64 bits:
//   [63:32] data word
//   [31:2]  address tag, the full word address of the cached word
//   [1]     dirty
//   [0]     valid
package dcache_pkg;

	// Controller states.
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		RD_WRITEBACK,
		RD_FILL,
		RD_UNCACHED,
		WR_BUS,
		WAIT_END
	} cache_state_e;

	// Access kinds, as picked by the decoder in LOOKUP.
	typedef enum logic [2:0] {
		READ_HIT,
		READ_FILL,
		READ_EVICT_FILL,
		READ_UNCACHED,
		WRITE_LOCAL,
		WRITE_EVICT,
		WRITE_UNCACHED
	} access_kind_e;

endpackage

`default_nettype wire

/* design/dcache_line_store.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_store (
	input wire i_clock,
	input wire i_reset,
	input wire i_write,
	input wire [`DCACHE_INDEX_BITS - 1:0] i_index,
	input wire [63:0] i_wdata,
	output logic [63:0] o_line,
	output logic o_initialized
);

	localparam int LINES = 1 << `DCACHE_INDEX_BITS;

	logic [63:0] mem [LINES];

	logic [`DCACHE_INDEX_BITS - 1:0] sweep_index;

	logic write_enable;
	logic [`DCACHE_INDEX_BITS - 1:0] write_index;
	logic [63:0] write_word;

	// Sweep owns the write port until every line is cleared.
	assign write_enable = !o_initialized || i_write;
	assign write_index = o_initialized ? i_index : sweep_index;
	assign write_word = o_initialized ? i_wdata : 64'd0;

	// Clear sweep, one line per cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sweep_index <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			sweep_index <= sweep_index + 1'b1;
			if (sweep_index == '1) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// Read-first RAM, one cycle of read latency.
	always_ff @(posedge i_clock) begin
		if (write_enable) begin
			mem[write_index] <= write_word;
		end
		o_line <= mem[i_index];
	end

	// The controller may only write once the sweep is done.
	a_no_write_during_sweep: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!o_initialized |-> !i_write
	);

endmodule

`default_nettype wire

/* design/dcache_access_decode.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_access_decode (
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [63:0] i_line,
	input wire i_initialized,
	output dcache_pkg::access_kind_e o_kind
);

	import dcache_pkg::*;

	logic cacheable;
	logic line_valid;
	logic line_dirty;
	logic tag_match;
	logic hit;
	logic must_evict;

	// Nothing is cacheable until the clear sweep has finished.
	assign cacheable = i_initialized && (i_address < `DCACHE_UNCACHED_BASE);

	assign line_valid = i_line[0];
	assign line_dirty = i_line[1];

	// Tag holds the whole word address.
	assign tag_match = (i_line[31:2] == i_address[31:2]);

	assign hit = line_valid && tag_match;

	// Old word belongs elsewhere and memory is stale.
	assign must_evict = line_valid && line_dirty && !tag_match;

	always_comb begin
		if (!i_rw) begin
			// Read side.
			if (!cacheable) begin
				o_kind = READ_UNCACHED;
			end else if (hit) begin
				o_kind = READ_HIT;
			end else if (must_evict) begin
				o_kind = READ_EVICT_FILL;
			end else begin
				o_kind = READ_FILL;
			end
		end else begin
			// Write side.
			if (!cacheable) begin
				o_kind = WRITE_UNCACHED;
			end else if (must_evict) begin
				o_kind = WRITE_EVICT;
			end else begin
				// Same address, invalid or clean line.
				o_kind = WRITE_LOCAL;
			end
		end
	end

endmodule

`default_nettype wire

/* design/dcache_controller.sv */
`default_nettype none

module dcache_controller (
	input wire i_clock,
	input wire i_reset,

	// CPU port.
	input wire i_request,
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// Line store and decoder.
	input wire [63:0] i_line,
	input dcache_pkg::access_kind_e i_kind,
	output logic o_line_write,
	output logic [63:0] o_line_wdata,

	// Bus port.
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input wire i_bus_ready,
	input wire [31:0] i_bus_rdata
);

	import dcache_pkg::*;

	cache_state_e state;

	logic [31:0] line_data;
	logic [31:0] line_address;
	logic fill_done;
	logic lookup_write;

	assign line_data = i_line[63:32];
	assign line_address = {i_line[31:2], 2'b00};

	// Fill completes on the read handshake.
	assign fill_done = (state == RD_FILL) && i_bus_ready;

	// Cacheable writes update the line in LOOKUP even when evicting.
	assign lookup_write = (state == LOOKUP) && i_rw &&
		((i_kind == WRITE_LOCAL) || (i_kind == WRITE_EVICT));

	assign o_line_write = lookup_write || fill_done;

	// Fills land clean and writes land dirty.
	always_comb begin
		if (state == RD_FILL) begin
			o_line_wdata = {i_bus_rdata, i_address[31:2], 2'b01};
		end else begin
			o_line_wdata = {i_wdata, i_address[31:2], 2'b11};
		end
	end

	assign o_ready = i_request && (state == WAIT_END);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_request) begin
						state <= LOOKUP;
					end
				end

				// Line store now shows the line for i_address.
				LOOKUP: begin
					case (i_kind)
						READ_HIT: begin
							o_rdata <= line_data;
							state <= WAIT_END;
						end
						READ_FILL: begin
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b0;
							o_bus_address <= i_address;
							state <= RD_FILL;
						end
						READ_EVICT_FILL: begin
							// Write back first and fill afterwards.
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b1;
							o_bus_address <= line_address;
							o_bus_wdata <= line_data;
							state <= RD_WRITEBACK;
						end
						READ_UNCACHED: begin
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b0;
							o_bus_address <= i_address;
							state <= RD_UNCACHED;
						end
						WRITE_LOCAL: begin
							state <= WAIT_END;
						end
						WRITE_EVICT: begin
							// Old word leaves while the new one is stored.
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b1;
							o_bus_address <= line_address;
							o_bus_wdata <= line_data;
							state <= WR_BUS;
						end
						WRITE_UNCACHED: begin
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b1;
							o_bus_address <= i_address;
							o_bus_wdata <= i_wdata;
							state <= WR_BUS;
						end
						default: begin
							state <= WAIT_END;
						end
					endcase
				end

				RD_WRITEBACK: begin
					if (i_bus_ready) begin
						// Request stays up and turns into the fill read.
						o_bus_rw <= 1'b0;
						o_bus_address <= i_address;
						state <= RD_FILL;
					end
				end

				RD_FILL: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						state <= WAIT_END;
					end
				end

				RD_UNCACHED: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						state <= WAIT_END;
					end
				end

				WR_BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw <= 1'b0;
						state <= WAIT_END;
					end
				end

				// Hold the answer until the CPU lets go.
				WAIT_END: begin
					if (!i_request) begin
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// The CPU is answered only once the last bus transfer is over.
	a_ready_bus_quiet: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_ready |-> !o_bus_request
	);

	// A pending bus transfer holds until the slave answers.
	a_bus_request_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=>
			o_bus_request && $stable(o_bus_address) && $stable(o_bus_rw) &&
			(!o_bus_rw || $stable(o_bus_wdata))
	);

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
	input wire i_clock,
	input wire i_reset,

	// CPU port.
	input wire i_request,
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// Bus port.
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input wire i_bus_ready,
	input wire [31:0] i_bus_rdata
);

	import dcache_pkg::*;

	logic [`DCACHE_INDEX_BITS - 1:0] line_index;
	logic line_write;
	logic [63:0] line_wdata;
	logic [63:0] line;
	logic initialized;
	access_kind_e kind;

	// Word address bits select the line.
	assign line_index = i_address[`DCACHE_INDEX_BITS + 1:2];

	dcache_line_store u_line_store (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(line_write),
		.i_index(line_index),
		.i_wdata(line_wdata),
		.o_line(line),
		.o_initialized(initialized)
	);

	dcache_access_decode u_access_decode (
		.i_rw(i_rw),
		.i_address(i_address),
		.i_line(line),
		.i_initialized(initialized),
		.o_kind(kind)
	);

	dcache_controller u_controller (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.i_line(line),
		.i_kind(kind),
		.o_line_write(line_write),
		.o_line_wdata(line_wdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

/* tb/bus_memory_model.sv */
`default_nettype none

module bus_memory_model (
	input wire i_clock,
	input wire i_reset,
	input wire i_bus_request,
	input wire i_bus_rw,
	input wire [31:0] i_bus_address,
	input wire [31:0] i_bus_wdata,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata,
	output logic [31:0] o_read_total,
	output logic [31:0] o_write_total
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] mem [logic [31:0]];

	integer seed = 32'h0fbc_bf10;
	logic [31:0] random_value;
	logic pending;
	logic [1:0] delay;

	// Unwritten words read back a pattern of their own address.
	function automatic logic [31:0] fill_word(input logic [31:0] address);
		return {address[15:0], address[31:16]} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (mem.exists(address)) begin
			return mem[address];
		end
		return fill_word(address);
	endfunction

	initial begin
		o_bus_ready = 1'b0;
		o_bus_rdata = '0;
	end

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_ready <= 1'b0;
			o_bus_rdata <= '0;
			o_read_total <= '0;
			o_write_total <= '0;
			pending <= 1'b0;
			delay <= '0;
		end else if (o_bus_ready && i_bus_request) begin
			// Transfer completes on this edge.
			o_bus_ready <= 1'b0;
			pending <= 1'b0;
			if (i_bus_rw) begin
				mem[i_bus_address] = i_bus_wdata;
				o_write_total <= o_write_total + 1'b1;
			end else begin
				o_read_total <= o_read_total + 1'b1;
			end
		end else if (i_bus_request) begin
			if (!pending) begin
				// Pick 0 to 3 wait cycles for a new request.
				random_value = $random(seed);
				pending <= 1'b1;
				delay <= random_value[1:0];
			end else if (delay != 0) begin
				delay <= delay - 1'b1;
			end else begin
				o_bus_ready <= 1'b1;
				o_bus_rdata <= i_bus_rw ? 32'd0 : read_word(i_bus_address);
			end
		end
	end

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS = 24;
	localparam int CLEAR_CYCLES = 4100;
	localparam int CYCLE_LIMIT = 4 + CLEAR_CYCLES + ROWS * 40;
	localparam int LINES = 1 << `DCACHE_INDEX_BITS;

	logic clock;
	logic reset;
	logic request;
	logic rw;
	logic [31:0] address;
	logic [31:0] wdata;
	logic ready;
	logic [31:0] rdata;
	logic bus_request;
	logic bus_rw;
	logic [31:0] bus_address;
	logic [31:0] bus_wdata;
	logic bus_ready;
	logic [31:0] bus_rdata;
	logic [31:0] read_total;
	logic [31:0] write_total;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Stimulus table.
	string row_name [$];
	logic row_rw [$];
	logic [31:0] row_address [$];
	logic [31:0] row_wdata [$];
	logic row_timed [$];

	// Architectural memory and the expected line status.
	logic [31:0] shadow_mem [logic [31:0]];
	logic [29:0] shadow_tag [LINES];
	logic shadow_valid [LINES];
	logic shadow_dirty [LINES];

	// Bus transfers as {rw, address, data}.
	logic [64:0] expected_bus [$];
	logic [64:0] seen_bus [$];

	dcache_top u_dcache_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_memory_model u_bus_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_request(bus_request),
		.i_bus_rw(bus_rw),
		.i_bus_address(bus_address),
		.i_bus_wdata(bus_wdata),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_read_total(read_total),
		.o_write_total(write_total)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// Log each bus handshake before the edge that completes it.
	always @(negedge clock) begin
		if (!reset && bus_request && bus_ready) begin
			seen_bus.push_back({bus_rw, bus_address, bus_rw ? bus_wdata : bus_rdata});
		end
	end

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] memory_word(input logic [31:0] addr);
		if (shadow_mem.exists(addr)) begin
			return shadow_mem[addr];
		end
		return fill_word(addr);
	endfunction

	task automatic add_row(input string name, input logic row_write, input logic [31:0] addr,
		input logic [31:0] data, input logic timed);
		row_name.push_back(name);
		row_rw.push_back(row_write);
		row_address.push_back(addr);
		row_wdata.push_back(data);
		row_timed.push_back(timed);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Expected bus traffic and read data under the write-back rules.
	task automatic predict(input logic row_write, input logic [31:0] addr,
		input logic [31:0] data, output logic [31:0] expected_rdata);
		int index;
		logic [31:0] old_address;
		logic match;
		index = addr[`DCACHE_INDEX_BITS + 1:2];
		old_address = {shadow_tag[index], 2'b00};
		match = shadow_valid[index] && (shadow_tag[index] == addr[31:2]);
		expected_bus.delete();
		expected_rdata = memory_word(addr);
		if (addr >= `DCACHE_UNCACHED_BASE) begin
			expected_bus.push_back({row_write, addr, row_write ? data : expected_rdata});
		end else begin
			if (!match && shadow_valid[index] && shadow_dirty[index]) begin
				expected_bus.push_back({1'b1, old_address, memory_word(old_address)});
			end
			if (!row_write && !match) begin
				expected_bus.push_back({1'b0, addr, expected_rdata});
			end
			if (row_write) begin
				shadow_dirty[index] = 1'b1;
			end else if (!match) begin
				shadow_dirty[index] = 1'b0;
			end
			shadow_tag[index] = addr[31:2];
			shadow_valid[index] = 1'b1;
		end
		if (row_write) begin
			shadow_mem[addr] = data;
		end
	endtask

	// One CPU access that counts edges from request to ready.
	task automatic access_cpu(input string name, input logic row_write,
		input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] data_out, output int edges);
		@(posedge clock);
		request <= 1'b1;
		rw <= row_write;
		address <= addr;
		wdata <= data;
		edges = 0;
		@(negedge clock);
		while (!ready) begin
			@(posedge clock);
			edges++;
			@(negedge clock);
		end
		data_out = rdata;
		@(posedge clock);
		request <= 1'b0;
		@(negedge clock);
		check_value({name, " ready after drop"}, 0, ready);
	endtask

	task automatic run_row(input int n);
		logic [31:0] expected_rdata;
		logic [31:0] actual_rdata;
		logic [31:0] reads_before;
		logic [31:0] writes_before;
		int edges;
		int reads;
		predict(row_rw[n], row_address[n], row_wdata[n], expected_rdata);
		seen_bus.delete();
		reads_before = read_total;
		writes_before = write_total;
		access_cpu(row_name[n], row_rw[n], row_address[n], row_wdata[n], actual_rdata, edges);
		if (!row_rw[n]) begin
			check_value({row_name[n], " rdata"}, expected_rdata, actual_rdata);
		end
		if (row_timed[n]) begin
			check_value({row_name[n], " ready cycles"}, 2, edges);
		end
		check_value({row_name[n], " bus transfers"}, expected_bus.size(), seen_bus.size());
		reads = 0;
		foreach (expected_bus[i]) begin
			if (!expected_bus[i][64]) begin
				reads++;
			end
			if (i < seen_bus.size()) begin
				check_value($sformatf("%s bus %0d rw", row_name[n], i),
					expected_bus[i][64], seen_bus[i][64]);
				check_value($sformatf("%s bus %0d address", row_name[n], i),
					expected_bus[i][63:32], seen_bus[i][63:32]);
				check_value($sformatf("%s bus %0d data", row_name[n], i),
					expected_bus[i][31:0], seen_bus[i][31:0]);
			end
		end
		check_value({row_name[n], " memory reads"}, reads, read_total - reads_before);
		check_value({row_name[n], " memory writes"}, expected_bus.size() - reads,
			write_total - writes_before);
	endtask

	initial begin
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		foreach (shadow_valid[i]) begin
			shadow_valid[i] = 1'b0;
			shadow_dirty[i] = 1'b0;
			shadow_tag[i] = '0;
		end

		// Adding 32'h4000 to an address keeps its index and changes its tag.
		add_row("rd_miss_a", 1'b0, 32'h0000_0100, 32'h0, 1'b0);
		add_row("rd_hit_a", 1'b0, 32'h0000_0100, 32'h0, 1'b1);
		add_row("wr_local_b", 1'b1, 32'h0000_0200, 32'h1111_2222, 1'b1);
		add_row("rd_hit_b", 1'b0, 32'h0000_0200, 32'h0, 1'b1);
		add_row("rd_evict_b", 1'b0, 32'h0000_4200, 32'h0, 1'b0);
		add_row("rd_hit_evict", 1'b0, 32'h0000_4200, 32'h0, 1'b1);
		add_row("rd_refill_b", 1'b0, 32'h0000_0200, 32'h0, 1'b0);
		add_row("wr_local_c", 1'b1, 32'h0000_0300, 32'hcafe_0001, 1'b1);
		add_row("wr_evict_c", 1'b1, 32'h0000_8300, 32'hcafe_0002, 1'b0);
		add_row("rd_hit_c", 1'b0, 32'h0000_8300, 32'h0, 1'b1);
		add_row("rd_evict_c", 1'b0, 32'h0000_0300, 32'h0, 1'b0);
		add_row("rd_uncached_a", 1'b0, 32'h4000_0100, 32'h0, 1'b0);
		add_row("wr_uncached_a", 1'b1, 32'h4000_0100, 32'hdead_beef, 1'b0);
		add_row("rd_uncached_b", 1'b0, 32'h4000_0100, 32'h0, 1'b0);
		add_row("rd_hit_after_uncached", 1'b0, 32'h0000_0100, 32'h0, 1'b1);
		add_row("wr_uncached_b", 1'b1, 32'h8000_0300, 32'h0bad_f00d, 1'b0);
		add_row("rd_hit_c_again", 1'b0, 32'h0000_0300, 32'h0, 1'b1);
		add_row("wr_local_d", 1'b1, 32'h0000_0100, 32'h1234_5678, 1'b1);
		add_row("wr_local_d_again", 1'b1, 32'h0000_0100, 32'h8765_4321, 1'b1);
		add_row("rd_evict_d", 1'b0, 32'h0000_c100, 32'h0, 1'b0);
		add_row("wr_local_e", 1'b1, 32'h0000_3ffc, 32'h5555_aaaa, 1'b1);
		add_row("rd_uncached_c", 1'b0, 32'hffff_fffc, 32'h0, 1'b0);
		add_row("rd_evict_e", 1'b0, 32'h0000_7ffc, 32'h0, 1'b0);
		add_row("rd_hit_d", 1'b0, 32'h0000_c100, 32'h0, 1'b1);

		repeat (4) @(posedge clock);
		reset <= 1'b0;
		// Line store clear sweep.
		repeat (CLEAR_CYCLES) @(posedge clock);

		for (int n = 0; n < row_name.size(); n++) begin
			run_row(n);
		end

		repeat (2) @(posedge clock);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/dcache_pkg.sv
design/dcache_line_store.sv
design/dcache_access_decode.sv
design/dcache_controller.sv
design/dcache_top.sv
tb/bus_memory_model.sv
tb/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/dcache_line_store.sv
      - design/dcache_access_decode.sv
      - design/dcache_controller.sv
      - design/dcache_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/bus_memory_model.sv
      - tb/dcache_tb.sv
